//--- logic/backendCtrl.sv
/*
 * Backend access sequencer
 * Reads a path into the stash, serves the command, writes the path back
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module backendCtrl (
	input logic Clock,
	input logic rstN,
	input oramPkg::feCmd_t cmd,
	input logic CommandValid,
	output logic CommandReady,
	output logic [`FED_WIDTH-1:0] LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input logic [`FED_WIDTH-1:0] StoreData,
	input logic StoreValid,
	output logic StoreReady,
	output logic [`DDR_A_WIDTH-1:0] DRAMCommandAddress,
	output logic DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,
	output logic insValid,
	output oramPkg::oramBlock_t insBlock,
	output logic [`ORAM_U-1:0] lookPAddr,
	input logic lookHit,
	input oramPkg::oramBlock_t lookBlock,
	output logic updValid,
	output oramPkg::oramBlock_t updBlock,
	output logic [`ORAM_L-1:0] evQueryLeaf,
	output logic [`ORAM_LV_WIDTH-1:0] evQueryLevel,
	output logic evTake,
	input logic evHit,
	input oramPkg::oramBlock_t evBlock,
	input logic full,
	output logic [`ORAM_L-1:0] leaf,
	output logic [`ORAM_LV_WIDTH-1:0] level,
	output logic [`ORAM_SLOT_WIDTH-1:0] slot,
	input logic [`DDR_A_WIDTH-1:0] addr,
	output oramPkg::oramBlock_t plainIn,
	output logic [`DDR_A_WIDTH-1:0] wrAddr,
	output logic [`DDR_A_WIDTH-1:0] rdAddr,
	input oramPkg::oramBlock_t plainOut
);
	import oramPkg::*;

	localparam int CW = `ORAM_LV_WIDTH + `ORAM_SLOT_WIDTH;
	localparam logic [CW-1:0] LAST_BEAT = CW'((`ORAM_L + 1) * `ORAM_Z - 1);
	localparam logic [`ORAM_LV_WIDTH-1:0] LEAF_LEVEL = `ORAM_L;

	typedef enum logic [2:0] {
		ST_IDLE, ST_RD_ISSUE, ST_RD_COLLECT, ST_SERVICE, ST_LOAD, ST_WB, ST_DONE
	} state_t;

	state_t state;
	feCmd_t cur;
	logic [CW-1:0] issueCnt;
	logic [CW-1:0] returnCnt;
	logic [CW-1:0] wbCnt;
	logic [CW-1:0] beat;
	logic cmdSent;
	logic wordSent;
	logic cmdFire;
	logic wordFire;
	logic readFire;
	logic wbStep;

	assign cmdFire = DRAMCommandValid && DRAMCommandReady;
	assign wordFire = DRAMWriteDataValid && DRAMWriteDataReady;
	assign readFire = DRAMReadDataValid && DRAMReadDataReady;
	// A write beat ends once both command and word are taken
	assign wbStep = (state == ST_WB) && (cmdSent || cmdFire) && (wordSent || wordFire);

	// Frontend handshakes
	assign CommandReady = (state == ST_IDLE) && !full;
	assign StoreReady = (state == ST_SERVICE) && (cur.cmd != BE_READ);
	assign LoadValid = (state == ST_LOAD);

	//----------------------------------------------------------------------
	// Path position
	//----------------------------------------------------------------------

	always_comb begin
		case (state)
			ST_RD_ISSUE: beat = issueCnt;
			ST_RD_COLLECT: beat = returnCnt;
			default: beat = wbCnt;
		endcase
	end

	assign slot = beat[`ORAM_SLOT_WIDTH-1:0];
	// Reads go root to leaf, write-back leaf to root
	assign level = (state == ST_WB) ? LEAF_LEVEL - beat[CW-1:`ORAM_SLOT_WIDTH] :
		beat[CW-1:`ORAM_SLOT_WIDTH];
	assign leaf = cur.currentLeaf;
	assign rdAddr = addr;
	assign wrAddr = addr;

	// DRAM side
	assign DRAMCommandAddress = addr;
	assign DRAMCommand = (state == ST_WB);
	assign DRAMCommandValid = (state == ST_RD_ISSUE) || ((state == ST_WB) && !cmdSent);
	assign DRAMWriteDataValid = (state == ST_WB) && !wordSent;
	assign DRAMReadDataReady = (state == ST_RD_COLLECT);

	// Stash side
	// Real blocks carry a zero pad field after decryption
	assign insValid = readFire && (plainOut.pad == '0);
	assign insBlock = plainOut;
	assign lookPAddr = cur.pAddr;
	assign evQueryLeaf = cur.currentLeaf;
	assign evQueryLevel = level;
	assign evTake = wbStep && evHit;
	assign plainIn = evHit ? evBlock : '0;
	assign updValid = (state == ST_SERVICE) && ((cur.cmd == BE_READ) || StoreValid);

	// Served block is retagged with the new leaf
	always_comb begin
		updBlock = '0;
		updBlock.valid = 1'b1;
		updBlock.pAddr = cur.pAddr;
		updBlock.leaf = cur.remappedLeaf;
		updBlock.data = lookHit ? lookBlock.data : '0;
		if (cur.cmd != BE_READ) begin
			updBlock.data = StoreData;
		end
	end

	//----------------------------------------------------------------------
	// Sequencer
	//----------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= ST_IDLE;
			issueCnt <= '0;
			returnCnt <= '0;
			wbCnt <= '0;
			cmdSent <= 1'b0;
			wordSent <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (CommandValid && CommandReady) begin
						state <= (cmd.cmd == BE_APPEND) ? ST_SERVICE : ST_RD_ISSUE;
					end
				end
				ST_RD_ISSUE: begin
					if (cmdFire) begin
						issueCnt <= issueCnt + 1'b1;
						if (issueCnt == LAST_BEAT) begin
							state <= ST_RD_COLLECT;
						end
					end
				end
				ST_RD_COLLECT: begin
					if (readFire) begin
						returnCnt <= returnCnt + 1'b1;
						if (returnCnt == LAST_BEAT) begin
							state <= ST_SERVICE;
						end
					end
				end
				ST_SERVICE: begin
					if (cur.cmd == BE_READ) begin
						state <= ST_LOAD;
					end else if (StoreValid) begin
						state <= (cur.cmd == BE_APPEND) ? ST_DONE : ST_WB;
					end
				end
				ST_LOAD: begin
					if (LoadReady) begin
						state <= ST_WB;
					end
				end
				ST_WB: begin
					if (wbStep) begin
						cmdSent <= 1'b0;
						wordSent <= 1'b0;
						wbCnt <= wbCnt + 1'b1;
						if (wbCnt == LAST_BEAT) begin
							state <= ST_IDLE;
						end
					end else begin
						cmdSent <= cmdSent || cmdFire;
						wordSent <= wordSent || wordFire;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command and load payloads
	always_ff @(posedge Clock) begin
		if (CommandValid && CommandReady) begin
			cur <= cmd;
		end
		if (state == ST_SERVICE && cur.cmd == BE_READ) begin
			LoadData <= updBlock.data;
		end
	end

	loadHeld: assert property (
		@(posedge Clock) disable iff (!rstN)
		(LoadValid && !LoadReady) |=> (LoadValid && $stable(LoadData))
	) else $error("LoadValid or LoadData changed before the load was taken");

endmodule

//--- logic/cipherConfig.sv
/*
 * Cipher configuration registers
 * Holds the pad key and the enable bit, written through a strobe port
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module cipherConfig (
	input logic Clock,
	input logic rstN,
	input logic CfgWrite,
	input logic [`CFG_A_WIDTH-1:0] CfgAddr,
	input logic [`CFG_D_WIDTH-1:0] CfgData,
	output oramPkg::cipherCfg_t cfg
);
	import oramPkg::*;

	// Key and enable start cleared so the pad is zero after reset
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			cfg <= '0;
		end else if (CfgWrite) begin
			case (CfgAddr)
				CFG_KEY_LO: cfg.key[`CFG_D_WIDTH-1:0] <= CfgData;
				CFG_KEY_HI: cfg.key[`DDR_D_WIDTH-1:`CFG_D_WIDTH] <= CfgData;
				CFG_ENABLE: cfg.enable <= CfgData[0];
				default: begin
				end
			endcase
		end
	end

	// Only three registers exist
	cfgAddrInRange: assert property (
		@(posedge Clock) disable iff (!rstN)
		CfgWrite |-> (CfgAddr <= CFG_ENABLE)
	) else $error("cipher config write to unmapped address %0d", CfgAddr);

endmodule

//--- logic/oramBackend.sv
/*
 * Path ORAM backend top
 * Joins the sequencer, stash, address generator and word cipher
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module oramBackend (
	input logic Clock,
	input logic rstN,

	// Frontend
	input oramPkg::beCmd_t Command,
	input logic [`ORAM_U-1:0] PAddr,
	input logic [`ORAM_L-1:0] CurrentLeaf,
	input logic [`ORAM_L-1:0] RemappedLeaf,
	input logic CommandValid,
	output logic CommandReady,
	output logic [`FED_WIDTH-1:0] LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input logic [`FED_WIDTH-1:0] StoreData,
	input logic StoreValid,
	output logic StoreReady,

	// DRAM
	output logic [`DDR_A_WIDTH-1:0] DRAMCommandAddress,
	output logic DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [`DDR_D_WIDTH-1:0] DRAMReadData,
	input logic DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output logic [`DDR_D_WIDTH-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,

	// Cipher configuration
	input logic CfgWrite,
	input logic [`CFG_A_WIDTH-1:0] CfgAddr,
	input logic [`CFG_D_WIDTH-1:0] CfgData
);

	//----------------------------------------------------------------------
	// Internal nets
	//----------------------------------------------------------------------

	oramPkg::feCmd_t feCmd;
	oramPkg::cipherCfg_t cfg;
	oramPkg::oramBlock_t plainIn;
	oramPkg::oramBlock_t plainOut;
	oramPkg::oramBlock_t insBlock;
	oramPkg::oramBlock_t lookBlock;
	oramPkg::oramBlock_t updBlock;
	oramPkg::oramBlock_t evBlock;
	logic insValid;
	logic updValid;
	logic evTake;
	logic lookHit;
	logic evHit;
	logic full;
	logic [`ORAM_U-1:0] lookPAddr;
	logic [`ORAM_L-1:0] evQueryLeaf;
	logic [`ORAM_L-1:0] leaf;
	logic [`ORAM_LV_WIDTH-1:0] evQueryLevel;
	logic [`ORAM_LV_WIDTH-1:0] level;
	logic [`ORAM_SLOT_WIDTH-1:0] slot;
	logic [`DDR_A_WIDTH-1:0] addr;
	logic [`DDR_A_WIDTH-1:0] wrAddr;
	logic [`DDR_A_WIDTH-1:0] rdAddr;

	assign feCmd = '{
		cmd: Command,
		pAddr: PAddr,
		currentLeaf: CurrentLeaf,
		remappedLeaf: RemappedLeaf
	};

	//----------------------------------------------------------------------
	// Blocks
	//----------------------------------------------------------------------

	backendCtrl ctrl (.cmd(feCmd), .*);

	stash stashMem (.*);

	pathAddrGen addrGen (.*);

	cipherConfig cipherRegs (.*);

	// Words cross the cipher on their way to and from DRAM
	pathCipher cipher (
		.cipherIn(DRAMReadData),
		.cipherOut(DRAMWriteData),
		.*
	);

endmodule

//--- logic/oramPkg.sv
/*
 * ORAM backend types
 * Frontend command, tree block layout and cipher configuration
 */
`include "oram_consts.svh"

package oramPkg;

	// Frontend command codes
	typedef enum logic [`BE_CMD_WIDTH-1:0] {
		BE_READ   = 2'd0,
		BE_WRITE  = 2'd1,
		BE_APPEND = 2'd2
	} beCmd_t;

	// Register map of the cipher configuration port
	typedef enum logic [`CFG_A_WIDTH-1:0] {
		CFG_KEY_LO = 2'd0,
		CFG_KEY_HI = 2'd1,
		CFG_ENABLE = 2'd2
	} cfgAddr_t;

	// One block fills exactly one DRAM word
	typedef struct packed {
		logic valid;
		logic [`ORAM_U-1:0] pAddr;
		logic [`ORAM_L-1:0] leaf;
		logic [`FED_WIDTH-1:0] data;
		logic [`BLK_PAD_WIDTH-1:0] pad;
	} oramBlock_t;

	typedef struct packed {
		beCmd_t cmd;
		logic [`ORAM_U-1:0] pAddr;
		logic [`ORAM_L-1:0] currentLeaf;
		logic [`ORAM_L-1:0] remappedLeaf;
	} feCmd_t;

	typedef struct packed {
		logic enable;
		logic [`DDR_D_WIDTH-1:0] key;
	} cipherCfg_t;

endpackage

//--- logic/oram_consts.svh
/*
 * ORAM backend constants
 * Tree shape, block layout, stash and DRAM port sizes
 */
`ifndef ORAM_CONSTS_SVH
`define ORAM_CONSTS_SVH

// Tree shape
`define ORAM_L 3
`define ORAM_Z 2
`define ORAM_LV_WIDTH 2
`define ORAM_SLOT_WIDTH 1

// Block and frontend sizes
`define ORAM_U 6
`define FED_WIDTH 32
`define BE_CMD_WIDTH 2
`define BLK_PAD_WIDTH (`DDR_D_WIDTH - 1 - `ORAM_U - `ORAM_L - `FED_WIDTH)

// DRAM word and address
`define DDR_D_WIDTH 64
`define DDR_A_WIDTH 5

// Stash
`define STASH_C 8
`define STASH_I_WIDTH 3

// Cipher configuration port
`define CFG_A_WIDTH 2
`define CFG_D_WIDTH 32
`define CIPHER_MIX 64'h9E37_79B9_7F4A_7C15

`endif

//--- logic/pathAddrGen.sv
/*
 * Bucket address generator
 * Maps a leaf, a tree level and a bucket slot to a DRAM word address
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module pathAddrGen (
	input logic [`ORAM_L-1:0] leaf,
	input logic [`ORAM_LV_WIDTH-1:0] level,
	input logic [`ORAM_SLOT_WIDTH-1:0] slot,
	output logic [`DDR_A_WIDTH-1:0] addr
);

	logic [`DDR_A_WIDTH-1:0] levelBase;
	logic [`DDR_A_WIDTH-1:0] bucket;

	always_comb begin
		// Heap numbering puts level k at 2^k - 1
		levelBase = (`DDR_A_WIDTH'(1) << level) - `DDR_A_WIDTH'(1);
		// Leaf bits from the MSB choose the bucket within the level
		bucket = levelBase + `DDR_A_WIDTH'(leaf >> (`ORAM_L - level));
		addr = `DDR_A_WIDTH'(bucket * `ORAM_Z) + `DDR_A_WIDTH'(slot);
	end

endmodule

//--- logic/pathCipher.sv
/*
 * Path word cipher
 * Whitens DRAM words with a pad keyed by the word address
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module pathCipher (
	input oramPkg::cipherCfg_t cfg,
	input logic [`DDR_A_WIDTH-1:0] wrAddr,
	input oramPkg::oramBlock_t plainIn,
	input logic [`DDR_A_WIDTH-1:0] rdAddr,
	input logic [`DDR_D_WIDTH-1:0] cipherIn,
	output logic [`DDR_D_WIDTH-1:0] cipherOut,
	output oramPkg::oramBlock_t plainOut
);
	import oramPkg::*;

	// Key rotated by the address, then spread by an odd multiplier
	function automatic logic [`DDR_D_WIDTH-1:0] keyPad(
		input cipherCfg_t c,
		input logic [`DDR_A_WIDTH-1:0] a
	);
		logic [`DDR_D_WIDTH-1:0] rotated;
		rotated = (c.key << a) | (c.key >> (`DDR_D_WIDTH - a));
		return c.enable ? rotated * `CIPHER_MIX : '0;
	endfunction

	//----------------------------------------------------------------------
	// Datapaths
	//----------------------------------------------------------------------

	// Write side towards DRAM
	assign cipherOut = plainIn ^ keyPad(cfg, wrAddr);

	// Read side back to the controller
	// The XOR is its own inverse at a fixed address and key
	assign plainOut = oramBlock_t'(cipherIn ^ keyPad(cfg, rdAddr));

endmodule

//--- logic/stash.sv
/*
 * Block stash
 * Small associative store with lookup, insert, update and eviction search
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module stash (
	input logic Clock,
	input logic rstN,
	input logic insValid,
	input oramPkg::oramBlock_t insBlock,
	input logic [`ORAM_U-1:0] lookPAddr,
	input logic updValid,
	input oramPkg::oramBlock_t updBlock,
	input logic [`ORAM_L-1:0] evQueryLeaf,
	input logic [`ORAM_LV_WIDTH-1:0] evQueryLevel,
	input logic evTake,
	output logic lookHit,
	output oramPkg::oramBlock_t lookBlock,
	output logic evHit,
	output oramPkg::oramBlock_t evBlock,
	output logic full
);
	import oramPkg::*;

	oramBlock_t entry [`STASH_C];
	logic [`STASH_C-1:0] used;
	logic [`STASH_I_WIDTH-1:0] lookIdx;
	logic [`STASH_I_WIDTH-1:0] matchIdx;
	logic [`STASH_I_WIDTH-1:0] freeIdx;
	logic [`STASH_I_WIDTH-1:0] updIdx;
	logic [`STASH_I_WIDTH-1:0] evIdx;
	logic updHit;
	logic doInsert;

	// Lowest used entry holding this address, hit flag on top
	function automatic logic [`STASH_I_WIDTH:0] findPAddr(input logic [`ORAM_U-1:0] a);
		logic [`STASH_I_WIDTH:0] res;
		res = '0;
		for (int i = `STASH_C - 1; i >= 0; i--) begin
			if (used[i] && entry[i].pAddr == a) begin
				res = {1'b1, `STASH_I_WIDTH'(i)};
			end
		end
		return res;
	endfunction

	//----------------------------------------------------------------------
	// Searches
	//----------------------------------------------------------------------

	always_comb begin
		{lookHit, lookIdx} = findPAddr(lookPAddr);
		{updHit, matchIdx} = findPAddr(updBlock.pAddr);
		freeIdx = '0;
		evHit = 1'b0;
		evIdx = '0;
		// Downward scan leaves the lowest index
		for (int i = `STASH_C - 1; i >= 0; i--) begin
			if (!used[i]) begin
				freeIdx = `STASH_I_WIDTH'(i);
			end
			// Same path prefix down to the queried level
			if (used[i] && (entry[i].leaf >> (`ORAM_L - evQueryLevel)) ==
					(evQueryLeaf >> (`ORAM_L - evQueryLevel))) begin
				evHit = 1'b1;
				evIdx = `STASH_I_WIDTH'(i);
			end
		end
		updIdx = updHit ? matchIdx : freeIdx;
	end

	assign full = &used;
	assign lookBlock = entry[lookIdx];
	assign evBlock = entry[evIdx];
	// Dummy blocks never take an entry
	assign doInsert = insValid && insBlock.valid && !full;

	//----------------------------------------------------------------------
	// Storage
	//----------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			used <= '0;
		end else begin
			if (doInsert) begin
				used[freeIdx] <= 1'b1;
			end
			if (updValid) begin
				used[updIdx] <= 1'b1;
			end
			if (evTake && evHit) begin
				used[evIdx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (doInsert) begin
			entry[freeIdx] <= insBlock;
		end
		if (updValid) begin
			entry[updIdx] <= updBlock;
		end
	end

	// Overflow recovery is not implemented
	noOverflow: assert property (
		@(posedge Clock) disable iff (!rstN)
		((insValid && insBlock.valid) || (updValid && !updHit)) |-> !full
	) else $error("stash overflow");

	// Each address lives in at most one entry
	for (genvar i = 0; i < `STASH_C; i++) begin : gDupA
		for (genvar j = i + 1; j < `STASH_C; j++) begin : gDupB
			uniquePAddr: assert property (
				@(posedge Clock) disable iff (!rstN)
				!(used[i] && used[j] && entry[i].pAddr == entry[j].pAddr)
			) else $error("stash entries %0d and %0d share pAddr", i, j);
		end
	end

endmodule

//--- sources.f
+incdir+logic
logic/oramPkg.sv
logic/cipherConfig.sv
logic/pathCipher.sv
logic/pathAddrGen.sv
logic/stash.sv
logic/backendCtrl.sv
logic/oramBackend.sv
tb/dramModel.sv
tb/oramBackendTb.sv

//--- tb/dramModel.sv
/*
 * Behavioral DRAM for the ORAM backend testbench
 * In-order reads with random latency, random ready stalls, separate write word port
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module dramModel #(
	parameter int DEPTH = 32
) (
	input logic Clock,
	input logic rstN,
	input logic [7:0] rnd,
	input logic [`DDR_A_WIDTH-1:0] DRAMCommandAddress,
	input logic DRAMCommand,
	input logic DRAMCommandValid,
	output logic DRAMCommandReady,
	output logic [`DDR_D_WIDTH-1:0] DRAMReadData,
	output logic DRAMReadDataValid,
	input logic DRAMReadDataReady,
	input logic [`DDR_D_WIDTH-1:0] DRAMWriteData,
	input logic DRAMWriteDataValid,
	output logic DRAMWriteDataReady
);

	logic [`DDR_D_WIDTH-1:0] mem [DEPTH];
	logic [`DDR_D_WIDTH-1:0] rdQ [$];
	int dueQ [$];
	logic [`DDR_A_WIDTH-1:0] wrAddrQ [$];
	logic [`DDR_D_WIDTH-1:0] wrWordQ [$];
	int cyc;

	always @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			// Memory starts as all dummy words
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] = '0;
			end
			rdQ.delete();
			dueQ.delete();
			wrAddrQ.delete();
			wrWordQ.delete();
			cyc = 0;
			DRAMCommandReady <= 1'b0;
			DRAMWriteDataReady <= 1'b0;
			DRAMReadDataValid <= 1'b0;
			DRAMReadData <= '0;
		end else begin
			cyc = cyc + 1;
			if (DRAMReadDataValid && DRAMReadDataReady) begin
				void'(rdQ.pop_front());
				void'(dueQ.pop_front());
			end
			if (DRAMCommandValid && DRAMCommandReady) begin
				if (DRAMCommand) begin
					wrAddrQ.push_back(DRAMCommandAddress);
				end else begin
					// Latency of 1 to 6 cycles, returned in issue order
					rdQ.push_back(mem[DRAMCommandAddress]);
					dueQ.push_back(cyc + int'(rnd[7:4]) % 6);
				end
			end
			if (DRAMWriteDataValid && DRAMWriteDataReady) begin
				wrWordQ.push_back(DRAMWriteData);
			end
			// Command and word pair up in order
			if (wrAddrQ.size() > 0 && wrWordQ.size() > 0) begin
				mem[wrAddrQ.pop_front()] = wrWordQ.pop_front();
			end
			DRAMReadDataValid <= 1'b0;
			if (dueQ.size() > 0) begin
				if (cyc >= dueQ[0]) begin
					DRAMReadDataValid <= 1'b1;
					DRAMReadData <= rdQ[0];
				end
			end
			// Ready about three cycles in four
			DRAMCommandReady <= (rnd[1:0] != 2'b00);
			DRAMWriteDataReady <= (rnd[3:2] != 2'b00);
		end
	end

endmodule

//--- tb/oramBackendTb.sv
/*
 * ORAM backend testbench
 * Random commands against a shadow map, checked by concurrent assertions
 */
`timescale 1ns/1ps
`include "oram_consts.svh"

module oramBackendTb;
	import oramPkg::*;

	localparam int NUM_ADDR = 6;
	localparam int DIRECTED_CMDS = 4;
	localparam int PLAIN_CMDS = 30;
	localparam int CIPHER_CMDS = 12;
	localparam int CYCLES_PER_CMD = 400;
	localparam int WATCHDOG_CYCLES =
		(DIRECTED_CMDS + PLAIN_CMDS + CIPHER_CMDS) * CYCLES_PER_CMD + 100;
	localparam logic [31:0] SEED = 32'h228d_47da;

	logic Clock = 1'b0;
	logic rstN;
	beCmd_t Command;
	logic [`ORAM_U-1:0] PAddr;
	logic [`ORAM_L-1:0] CurrentLeaf;
	logic [`ORAM_L-1:0] RemappedLeaf;
	logic CommandValid;
	logic CommandReady;
	logic [`FED_WIDTH-1:0] LoadData;
	logic LoadValid;
	logic LoadReady;
	logic [`FED_WIDTH-1:0] StoreData;
	logic StoreValid;
	logic StoreReady;
	logic [`DDR_A_WIDTH-1:0] DRAMCommandAddress;
	logic DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	logic [`DDR_D_WIDTH-1:0] DRAMReadData;
	logic DRAMReadDataValid;
	logic DRAMReadDataReady;
	logic [`DDR_D_WIDTH-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;
	logic CfgWrite;
	logic [`CFG_A_WIDTH-1:0] CfgAddr;
	logic [`CFG_D_WIDTH-1:0] CfgData;
	logic [7:0] dramRnd;

	// Shadow map and access tracking
	logic [31:0] stimLfsr;
	logic [31:0] dramLfsr;
	logic [`FED_WIDTH-1:0] shadowData [NUM_ADDR];
	logic [`ORAM_L-1:0] shadowLeaf [NUM_ADDR];
	logic touched [NUM_ADDR];
	logic [`FED_WIDTH-1:0] expLoad;
	logic encOn;
	logic [`ORAM_L-1:0] accLeaf;
	logic [2:0] rdBeat;
	logic [2:0] wrBeat;
	logic [2:0] wdBeat;
	logic dramCmdFire;
	logic dramWordFire;
	logic [5:0] ctrlOuts;

	oramBackend uut (.*);

	dramModel #(.DEPTH(32)) dram (.rnd(dramRnd), .*);

	always #10 Clock = ~Clock;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrBits(inout logic [31:0] s, input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = s[31] ^ s[21] ^ s[1] ^ s[0];
			s = {s[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Walk down from the root, left child 2b+1, right child 2b+2
	function automatic logic [`DDR_A_WIDTH-1:0] pathAddr(
		input logic [`ORAM_L-1:0] lf,
		input int lvl,
		input int sl
	);
		int bucket;
		bucket = 0;
		for (int k = 0; k < lvl; k++) begin
			bucket = 2 * bucket + 1 + int'(lf[`ORAM_L-1-k]);
		end
		return `DDR_A_WIDTH'(bucket * `ORAM_Z + sl);
	endfunction

	// Dummy, or a current block whose leaf passes through this bucket
	function automatic logic wordOk(
		input logic [`DDR_D_WIDTH-1:0] w,
		input logic [`ORAM_L-1:0] pathLeaf,
		input logic [2:0] beat
	);
		oramBlock_t b;
		int lvl;
		b = oramBlock_t'(w);
		lvl = `ORAM_L - int'(beat[2:1]);
		if (w == '0) begin
			return 1'b1;
		end
		if (!b.valid || b.pad != '0 || b.pAddr >= NUM_ADDR) begin
			return 1'b0;
		end
		return (b.leaf == shadowLeaf[b.pAddr]) && (b.data == shadowData[b.pAddr]) &&
			((b.leaf >> (`ORAM_L - lvl)) == (pathLeaf >> (`ORAM_L - lvl)));
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	//----------------------------------------------------------------------
	// Access tracking
	//----------------------------------------------------------------------

	assign dramCmdFire = DRAMCommandValid && DRAMCommandReady;
	assign dramWordFire = DRAMWriteDataValid && DRAMWriteDataReady;
	assign ctrlOuts = {CommandReady, LoadValid, StoreReady, DRAMCommandValid,
		DRAMWriteDataValid, DRAMReadDataReady};

	always @(posedge Clock) begin
		dramRnd <= 8'(lfsrBits(dramLfsr, 8));
	end

	always @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			accLeaf <= '0;
			rdBeat <= '0;
			wrBeat <= '0;
			wdBeat <= '0;
		end else begin
			if (CommandValid && CommandReady) begin
				accLeaf <= CurrentLeaf;
				rdBeat <= '0;
				wrBeat <= '0;
				wdBeat <= '0;
			end
			if (dramCmdFire && !DRAMCommand) begin
				rdBeat <= rdBeat + 1'b1;
			end
			if (dramCmdFire && DRAMCommand) begin
				wrBeat <= wrBeat + 1'b1;
			end
			if (dramWordFire) begin
				wdBeat <= wdBeat + 1'b1;
			end
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	resetState: assert property (@(posedge Clock) $rose(rstN) |-> ctrlOuts == 6'b100000)
		else reportFailure($sformatf("CHECK FAILED t=%0t ctrlOuts got %b expected %b",
			$time, $sampled(ctrlOuts), 6'b100000));

	loadMatches: assert property (
		@(posedge Clock) disable iff (!rstN)
		(LoadValid && LoadReady) |-> LoadData == expLoad
	) else reportFailure($sformatf("CHECK FAILED t=%0t LoadData got %h expected %h",
		$time, $sampled(LoadData), $sampled(expLoad)));

	// Root to leaf, slot 0 before slot 1
	readPath: assert property (
		@(posedge Clock) disable iff (!rstN)
		(dramCmdFire && !DRAMCommand) |->
			DRAMCommandAddress == pathAddr(accLeaf, int'(rdBeat[2:1]), int'(rdBeat[0]))
	) else reportFailure($sformatf("CHECK FAILED t=%0t DRAMCommandAddress got %0d expected %0d",
		$time, $sampled(DRAMCommandAddress),
		pathAddr($sampled(accLeaf), int'($sampled(rdBeat[2:1])), int'($sampled(rdBeat[0])))));

	// Same buckets, leaf back up to root
	writePath: assert property (
		@(posedge Clock) disable iff (!rstN)
		(dramCmdFire && DRAMCommand) |->
			DRAMCommandAddress == pathAddr(accLeaf, `ORAM_L - int'(wrBeat[2:1]), int'(wrBeat[0]))
	) else reportFailure($sformatf("CHECK FAILED t=%0t DRAMCommandAddress got %0d expected %0d",
		$time, $sampled(DRAMCommandAddress), pathAddr($sampled(accLeaf),
		`ORAM_L - int'($sampled(wrBeat[2:1])), int'($sampled(wrBeat[0])))));

	plainWords: assert property (
		@(posedge Clock) disable iff (!rstN)
		(dramWordFire && !encOn) |-> wordOk(DRAMWriteData, accLeaf, wdBeat)
	) else reportFailure($sformatf(
		"DRAM write word %h at %0t is neither a dummy nor a current block on the path",
		$sampled(DRAMWriteData), $time));

	loadStable: assert property (
		@(posedge Clock) disable iff (!rstN)
		(LoadValid && !LoadReady) |=> (LoadValid && $stable(LoadData))
	) else reportFailure($sformatf("CHECK FAILED t=%0t LoadData got %h expected %h (LoadValid %b)",
		$time, $sampled(LoadData), $past(LoadData), $sampled(LoadValid)));

	noCmdDuringLoad: assert property (
		@(posedge Clock) disable iff (!rstN)
		LoadValid |-> !CommandReady
	) else reportFailure($sformatf("CHECK FAILED t=%0t CommandReady got %b expected %b",
		$time, $sampled(CommandReady), 1'b0));

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------

	task automatic applyReset();
		rstN <= 1'b0;
		repeat (3) @(posedge Clock);
		rstN <= 1'b1;
	endtask

	task automatic clearShadow();
		for (int i = 0; i < NUM_ADDR; i++) begin
			shadowData[i] = '0;
			shadowLeaf[i] = '0;
			touched[i] = 1'b0;
		end
	endtask

	task automatic writeCfg(input cfgAddr_t a, input logic [`CFG_D_WIDTH-1:0] d);
		@(posedge Clock);
		CfgWrite <= 1'b1;
		CfgAddr <= a;
		CfgData <= d;
		@(posedge Clock);
		CfgWrite <= 1'b0;
	endtask

	// Returns on the edge that takes the command
	task automatic sendCommand(
		input beCmd_t c,
		input int a,
		input logic [`ORAM_L-1:0] curLeaf,
		input logic [`ORAM_L-1:0] newLeaf
	);
		@(posedge Clock);
		Command <= c;
		PAddr <= `ORAM_U'(a);
		CurrentLeaf <= curLeaf;
		RemappedLeaf <= newLeaf;
		CommandValid <= 1'b1;
		do begin
			@(posedge Clock);
		end while (!CommandReady);
		CommandValid <= 1'b0;
	endtask

	task automatic sendStore(input logic [`FED_WIDTH-1:0] d);
		StoreData <= d;
		StoreValid <= 1'b1;
		do begin
			@(posedge Clock);
		end while (!StoreReady);
		StoreValid <= 1'b0;
	endtask

	// Holds LoadReady low for the given cycles once LoadValid shows
	task automatic takeLoad(input int hold);
		do begin
			@(posedge Clock);
		end while (!LoadValid);
		repeat (hold) @(posedge Clock);
		LoadReady <= 1'b1;
		@(posedge Clock);
		LoadReady <= 1'b0;
	endtask

	task automatic doRead(input int a, input logic [`ORAM_L-1:0] newLeaf, input int hold);
		sendCommand(BE_READ, a, shadowLeaf[a], newLeaf);
		expLoad = shadowData[a];
		shadowLeaf[a] = newLeaf;
		touched[a] = 1'b1;
		takeLoad(hold);
	endtask

	task automatic doWrite(
		input int a,
		input logic [`ORAM_L-1:0] newLeaf,
		input logic [`FED_WIDTH-1:0] d
	);
		sendCommand(BE_WRITE, a, shadowLeaf[a], newLeaf);
		shadowLeaf[a] = newLeaf;
		shadowData[a] = d;
		touched[a] = 1'b1;
		sendStore(d);
	endtask

	// Only for an address that exists nowhere yet
	task automatic doAppend(
		input int a,
		input logic [`ORAM_L-1:0] newLeaf,
		input logic [`FED_WIDTH-1:0] d
	);
		sendCommand(BE_APPEND, a, newLeaf, newLeaf);
		shadowLeaf[a] = newLeaf;
		shadowData[a] = d;
		touched[a] = 1'b1;
		sendStore(d);
	endtask

	task automatic randomCommand();
		int a;
		logic [1:0] kind;
		logic [`ORAM_L-1:0] newLeaf;
		logic [`FED_WIDTH-1:0] d;
		int hold;
		a = int'(lfsrBits(stimLfsr, 8)) % NUM_ADDR;
		kind = 2'(lfsrBits(stimLfsr, 2));
		newLeaf = `ORAM_L'(lfsrBits(stimLfsr, `ORAM_L));
		d = lfsrBits(stimLfsr, 32);
		hold = int'(lfsrBits(stimLfsr, 3));
		if (kind == 2'd2 && !touched[a]) begin
			doAppend(a, newLeaf, d);
		end else if (kind[0]) begin
			doWrite(a, newLeaf, d);
		end else begin
			doRead(a, newLeaf, hold);
		end
	endtask

	task automatic waitIdle();
		do begin
			@(posedge Clock);
		end while (!CommandReady);
	endtask

	initial begin
		rstN = 1'b0;
		Command = BE_READ;
		PAddr = '0;
		CurrentLeaf = '0;
		RemappedLeaf = '0;
		CommandValid = 1'b0;
		LoadReady = 1'b0;
		StoreData = '0;
		StoreValid = 1'b0;
		CfgWrite = 1'b0;
		CfgAddr = '0;
		CfgData = '0;
		dramRnd = '0;
		stimLfsr = SEED;
		dramLfsr = SEED;
		expLoad = '0;
		encOn = 1'b0;
		clearShadow();
		applyReset();

		// Plaintext phase, long load hold first
		doWrite(0, 3'd5, 32'hcafe_0001);
		doRead(0, 3'd2, 6);
		doAppend(5, 3'd7, 32'h0bad_5eed);
		doRead(5, 3'd1, 2);
		repeat (PLAIN_CMDS) randomCommand();
		waitIdle();

		// Fresh tree, then keyed pad switched on
		applyReset();
		clearShadow();
		writeCfg(CFG_KEY_LO, 32'h0f7b_d248);
		writeCfg(CFG_KEY_HI, 32'h5a3c_96e1);
		writeCfg(CFG_ENABLE, 32'h1);
		encOn = 1'b1;
		repeat (CIPHER_CMDS) randomCommand();
		waitIdle();

		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog sized from the command count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge Clock);
		reportFailure($sformatf("Watchdog expired after %0d cycles with commands still pending",
			WATCHDOG_CYCLES));
	end

endmodule
